// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  localparam int addr_w      = 12;   // word address
  localparam int tag_w       = 6;
  localparam int index_w     = 4;    // 16 lines
  localparam int offset_w    = 2;    // 4 words per line
  localparam int data_w      = 32;
  localparam int line_w      = 128;  // also the memory transfer width
  localparam int num_lines   = 1 << index_w;
  localparam int line_words  = 1 << offset_w;
  localparam int mem_lines   = 1024;
  localparam int mem_latency = 3;    // request start to ready pulse

  // memory word w starts as w * 3 + this base
  localparam logic [data_w-1:0] mem_init_base = 32'h1000_0000;

  typedef struct packed {
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
  } addr_fields_t;

  typedef union packed {
    logic [addr_w-1:0] raw;    // flat word address
    addr_fields_t      f;      // cache view of the same word
  } cache_addr_u;

  typedef struct packed {
    logic                       rden;
    logic                       wren;
    logic [tag_w+index_w-1:0]   line_addr;  // tag and index
    logic [line_w-1:0]          wdata;
  } mem_req_t;

  typedef struct packed {
    logic cache_rden;
    logic cache_wren;
    logic cache_insel;   // array write data from memory line
    logic set_dirty;
    logic set_valid;
    logic replace_tag;
    logic tag_sel;       // stored tag on the memory address
    logic stall;
    logic mem_rden;
    logic mem_wren;
  } ctrl_t;

endpackage

// ==== hdl/cache_fsm.sv ====
module cache_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                cpu_rden,
  input  logic                cpu_wren,
  input  logic                hit,
  input  logic                dirty,
  input  logic                mem_ready,
  output cache_pkg::ctrl_t    ctrl
);

  typedef enum logic [2:0] {
    IDLE,
    COMPARE_TAG,
    WRITE_BACK,
    ALLOCATE,
    CACHE_ACCESS
  } state_t;

  state_t state_q;
  state_t next_state;
  logic   rden_q;   // strobes of the request under service
  logic   wren_q;
  logic   new_req;

  assign new_req = cpu_rden | cpu_wren;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= next_state;
    end
  end

  // request strobes follow the cpu only while not stalled
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rden_q <= 1'b0;
      wren_q <= 1'b0;
    end else if (!ctrl.stall) begin
      rden_q <= cpu_rden;
      wren_q <= cpu_wren;
    end
  end

  always_comb begin
    ctrl       = '0;
    next_state = state_q;
    case (state_q)
      IDLE: begin
        if (new_req) begin
          next_state = COMPARE_TAG;
        end
      end

      COMPARE_TAG: begin
        if (hit) begin
          ctrl.cache_rden = rden_q;  // read hit returns now
          ctrl.cache_wren = wren_q;  // write hit lands at end of cycle
          ctrl.set_valid  = wren_q;
          ctrl.set_dirty  = wren_q;
          // a second request can be taken right away
          if (new_req) begin
            next_state = COMPARE_TAG;
          end else begin
            next_state = IDLE;
          end
        end else if (dirty) begin
          ctrl.mem_wren = 1'b1;      // evict the old line first
          ctrl.tag_sel  = 1'b1;      // address of the victim
          ctrl.stall    = 1'b1;
          next_state    = WRITE_BACK;
        end else begin
          ctrl.mem_rden = 1'b1;      // fetch starts here
          ctrl.stall    = 1'b1;
          next_state    = ALLOCATE;
        end
      end

      WRITE_BACK: begin
        ctrl.mem_wren = 1'b1;        // held until the ready pulse
        ctrl.tag_sel  = 1'b1;
        ctrl.stall    = 1'b1;
        if (mem_ready) begin
          next_state = ALLOCATE;
        end
      end

      ALLOCATE: begin
        ctrl.mem_rden = 1'b1;
        ctrl.stall    = 1'b1;
        if (mem_ready) begin
          ctrl.cache_wren  = 1'b1;   // refill from memory line
          ctrl.cache_insel = 1'b1;
          ctrl.replace_tag = 1'b1;
          ctrl.set_valid   = 1'b1;
          ctrl.set_dirty   = 1'b0;   // fresh line is clean
          next_state       = CACHE_ACCESS;
        end
      end

      CACHE_ACCESS: begin
        ctrl.cache_rden = rden_q;
        ctrl.cache_wren = wren_q;    // merge of the write-allocate word
        ctrl.set_valid  = wren_q;
        ctrl.set_dirty  = wren_q;
        if (new_req) begin
          next_state = COMPARE_TAG;
        end else begin
          next_state = IDLE;
        end
      end

      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

// ==== hdl/cache_store.sv ====
module cache_store (
  input  logic                              clk,
  input  logic                              rst,
  input  cache_pkg::cache_addr_u            cpu_addr,
  input  logic [cache_pkg::data_w-1:0]      cpu_wdata,
  input  cache_pkg::ctrl_t                  ctrl,
  input  logic [cache_pkg::line_w-1:0]      mem_rdata,
  output logic                              hit,
  output logic                              dirty,
  output logic [cache_pkg::data_w-1:0]      cpu_rdata,
  output logic                              cpu_rvalid,
  output cache_pkg::mem_req_t               mem_req
);

  cache_pkg::cache_addr_u               req_addr_q;
  logic [cache_pkg::data_w-1:0]         req_wdata_q;

  logic [cache_pkg::tag_w-1:0]          tag_q   [0:cache_pkg::num_lines-1];
  logic [cache_pkg::line_w-1:0]         data_q  [0:cache_pkg::num_lines-1];
  logic [cache_pkg::num_lines-1:0]      valid_q;
  logic [cache_pkg::num_lines-1:0]      dirty_q;

  logic [cache_pkg::index_w-1:0]        idx;
  logic [cache_pkg::line_w-1:0]         line_rd;
  logic [cache_pkg::line_w-1:0]         line_merged;
  logic [cache_pkg::line_w-1:0]         line_wr;
  logic [cache_pkg::tag_w-1:0]          mem_tag;

  // request register, frozen during a miss
  always_ff @(posedge clk) begin
    if (!ctrl.stall) begin
      req_addr_q  <= cpu_addr;
      req_wdata_q <= cpu_wdata;
    end
  end

  assign idx     = req_addr_q.f.index;
  assign line_rd = data_q[idx];

  assign hit   = valid_q[idx] && (tag_q[idx] == req_addr_q.f.tag);
  assign dirty = valid_q[idx] && dirty_q[idx];

  // cpu word dropped into the indexed line
  always_comb begin
    line_merged = line_rd;
    line_merged[req_addr_q.f.offset*cache_pkg::data_w +: cache_pkg::data_w] = req_wdata_q;
  end

  assign line_wr = ctrl.cache_insel ? mem_rdata : line_merged;

  always_ff @(posedge clk) begin
    if (ctrl.cache_wren) begin
      data_q[idx] <= line_wr;
    end
    if (ctrl.replace_tag) begin
      tag_q[idx] <= req_addr_q.f.tag;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ctrl.set_valid) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= ctrl.set_dirty;  // cleared on refill, set on write
    end
  end

  assign cpu_rdata  = line_rd[req_addr_q.f.offset*cache_pkg::data_w +: cache_pkg::data_w];
  assign cpu_rvalid = ctrl.cache_rden;

  // victim tag for write-back, request tag for the fetch
  assign mem_tag = ctrl.tag_sel ? tag_q[idx] : req_addr_q.f.tag;

  always_comb begin
    mem_req.rden      = ctrl.mem_rden;
    mem_req.wren      = ctrl.mem_wren;
    mem_req.line_addr = {mem_tag, idx};
    mem_req.wdata     = line_rd;
  end

endmodule

// ==== hdl/main_mem.sv ====
module main_mem (
  input  logic                            clk,
  input  logic                            rst,
  input  cache_pkg::mem_req_t             mem_req,
  output logic                            mem_ready,
  output logic [cache_pkg::line_w-1:0]    mem_rdata
);

  logic [cache_pkg::line_w-1:0]                    mem_q [0:cache_pkg::mem_lines-1];
  logic [$clog2(cache_pkg::mem_latency+1)-1:0]     cnt_q;
  logic                                            active;

  // every word starts from its own address
  initial begin
    cache_pkg::cache_addr_u wa;
    for (int ln = 0; ln < cache_pkg::mem_lines; ln++) begin
      for (int w = 0; w < cache_pkg::line_words; w++) begin
        {wa.f.tag, wa.f.index} = ln[cache_pkg::tag_w+cache_pkg::index_w-1:0];
        wa.f.offset            = w[cache_pkg::offset_w-1:0];
        mem_q[ln][w*cache_pkg::data_w +: cache_pkg::data_w] =
          cache_pkg::mem_init_base + 32'd3 * wa.raw;
      end
    end
  end

  assign active = mem_req.rden | mem_req.wren;

  // latency count, restarts after each pulse
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (!active || mem_ready) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign mem_ready = active && (cnt_q == cache_pkg::mem_latency - 1);

  always @(posedge clk) begin
    if (mem_ready && mem_req.wren) begin
      mem_q[mem_req.line_addr] <= mem_req.wdata;  // store at the pulse
    end
  end

  assign mem_rdata = mem_q[mem_req.line_addr];

endmodule

// ==== hdl/cache_top.sv ====
module cache_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cpu_rden,
  input  logic                            cpu_wren,
  input  cache_pkg::cache_addr_u          cpu_addr,
  input  logic [cache_pkg::data_w-1:0]    cpu_wdata,
  output logic [cache_pkg::data_w-1:0]    cpu_rdata,
  output logic                            cpu_rvalid,
  output logic                            stall
);

  cache_pkg::ctrl_t                  ctrl;
  cache_pkg::mem_req_t               mem_req;
  logic                              hit;
  logic                              dirty;
  logic                              mem_ready;
  logic [cache_pkg::line_w-1:0]      mem_rdata;

  cache_fsm fsm0 (
    .clk       (clk),
    .rst       (rst),
    .cpu_rden  (cpu_rden),
    .cpu_wren  (cpu_wren),
    .hit       (hit),
    .dirty     (dirty),
    .mem_ready (mem_ready),
    .ctrl      (ctrl)
  );

  cache_store store0 (
    .clk        (clk),
    .rst        (rst),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .ctrl       (ctrl),
    .mem_rdata  (mem_rdata),
    .hit        (hit),
    .dirty      (dirty),
    .cpu_rdata  (cpu_rdata),
    .cpu_rvalid (cpu_rvalid),
    .mem_req    (mem_req)
  );

  main_mem mem0 (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  assign stall = ctrl.stall;  // cpu back-pressure

endmodule

// ==== verification/cache_checker.sv ====
module cache_checker (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            cpu_rden,
  input  logic                            cpu_wren,
  input  cache_pkg::cache_addr_u          cpu_addr,
  input  logic [cache_pkg::data_w-1:0]    cpu_wdata,
  input  logic [cache_pkg::data_w-1:0]    cpu_rdata,
  input  logic                            cpu_rvalid,
  input  logic                            stall,
  input  logic                            exp_valid,
  input  logic [cache_pkg::data_w-1:0]    exp_data,
  input  logic                            end_run,
  output int                              mismatch_cnt,
  output int                              fail_cnt,
  output int                              read_cnt
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic                         has_table;   // directed row with its own expected word
    logic [cache_pkg::data_w-1:0] table_word;
    logic [cache_pkg::data_w-1:0] pred;
    logic [cache_pkg::addr_w-1:0] addr;
  } pend_t;

  logic [cache_pkg::data_w-1:0]    shadow [int];   // written words only
  pend_t                           pend_q [$];     // reads waiting for data
  logic                            ended;
  logic [cache_pkg::tag_w-1:0]     tag_m [0:cache_pkg::num_lines-1];  // lines the cache should hold
  logic [cache_pkg::num_lines-1:0] valid_m;
  logic                            cmp_q;   // request taken at the last edge
  logic                            hit_q;   // and it should hit
  logic                            rd_q;

  function automatic logic [cache_pkg::data_w-1:0] predict(
    input logic [cache_pkg::addr_w-1:0] a
  );
    logic [cache_pkg::data_w-1:0] w;
    if (shadow.exists(int'(a))) begin
      return shadow[int'(a)];
    end
    w = '0;
    w[cache_pkg::addr_w-1:0] = a;
    return cache_pkg::mem_init_base + 32'd3 * w;   // word as at power-up
  endfunction

  always @(posedge clk or posedge rst) begin
    pend_t                         p;
    logic [cache_pkg::index_w-1:0] ix;
    if (rst) begin
      pend_q.delete();
      mismatch_cnt = 0;
      fail_cnt     = 0;
      read_cnt     = 0;
      ended        = 1'b0;
      valid_m      = '0;
      cmp_q        = 1'b0;
      hit_q        = 1'b0;
      rd_q         = 1'b0;
    end else begin
      // returned data first, it belongs to an older request
      if (cpu_rvalid) begin
        if (pend_q.size() == 0) begin
          $display("%0t: read data returned with no read outstanding", $time);
          fail_cnt++;
        end else begin
          p = pend_q.pop_front();
          read_cnt++;
          if (cpu_rdata !== p.pred) begin
            $display("MISMATCH %0t cpu_rdata addr %03h expected %08h got %08h",
                     $time, p.addr, p.pred, cpu_rdata);
            mismatch_cnt++;
          end
          if (p.has_table && cpu_rdata !== p.table_word) begin
            $display("MISMATCH %0t cpu_rdata (table) addr %03h expected %08h got %08h",
                     $time, p.addr, p.table_word, cpu_rdata);
            mismatch_cnt++;
          end
        end
      end
      // tag compare cycle, a hit neither stalls nor delays its data
      if (cmp_q) begin
        if (stall !== !hit_q) begin
          $display("MISMATCH %0t stall expected %0b got %0b", $time, !hit_q, stall);
          mismatch_cnt++;
        end
        if (cpu_rvalid !== (hit_q && rd_q)) begin
          $display("MISMATCH %0t cpu_rvalid expected %0b got %0b",
                   $time, hit_q && rd_q, cpu_rvalid);
          mismatch_cnt++;
        end
      end
      cmp_q = !stall && (cpu_rden || cpu_wren);
      if (cmp_q) begin
        ix          = cpu_addr.f.index;
        hit_q       = valid_m[ix] && (tag_m[ix] == cpu_addr.f.tag);
        rd_q        = cpu_rden;
        tag_m[ix]   = cpu_addr.f.tag;   // both reads and writes allocate
        valid_m[ix] = 1'b1;
      end
      if (!stall && cpu_wren) begin
        shadow[int'(cpu_addr.raw)] = cpu_wdata;
      end else if (!stall && cpu_rden) begin
        p.has_table  = exp_valid;
        p.table_word = exp_data;
        p.pred       = predict(cpu_addr.raw);
        p.addr       = cpu_addr.raw;
        pend_q.push_back(p);
      end
      if (end_run && !ended) begin
        ended = 1'b1;
        if (pend_q.size() != 0) begin
          $display("%0d accepted read(s) never returned data", pend_q.size());
          fail_cnt += pend_q.size();
        end
      end
    end
  end

endmodule

// ==== verification/cache_tb.sv ====
module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int table_rows   = 24;
  localparam int random_reqs  = 200;
  localparam int reset_cycles = 10;
  localparam int cycle_ns     = 8;
  // a dirty miss waits for memory twice
  localparam int max_cycles   = reset_cycles +
    (table_rows + random_reqs) * (4 * cache_pkg::mem_latency + 6);

  typedef struct packed {
    logic                         rden;
    logic                         wren;
    logic [cache_pkg::addr_w-1:0] addr;
    logic [cache_pkg::data_w-1:0] data;   // write data or expected read word
  } stim_t;

  logic                            clk;
  logic                            rst;
  logic                            cpu_rden;
  logic                            cpu_wren;
  cache_pkg::cache_addr_u          cpu_addr;
  logic [cache_pkg::data_w-1:0]    cpu_wdata;
  logic [cache_pkg::data_w-1:0]    cpu_rdata;
  logic                            cpu_rvalid;
  logic                            stall;
  logic                            exp_valid;
  logic [cache_pkg::data_w-1:0]    exp_data;
  logic                            end_run;
  int                              mismatch_cnt;
  int                              fail_cnt;
  int                              read_cnt;
  logic [31:0]                     lfsr_q;
  logic [cache_pkg::tag_w-1:0]     rand_tags [0:3];
  stim_t                           stim_table [0:table_rows-1];

  cache_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .cpu_rden   (cpu_rden),
    .cpu_wren   (cpu_wren),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_rdata  (cpu_rdata),
    .cpu_rvalid (cpu_rvalid),
    .stall      (stall)
  );

  cache_checker chk0 (
    .clk          (clk),
    .rst          (rst),
    .cpu_rden     (cpu_rden),
    .cpu_wren     (cpu_wren),
    .cpu_addr     (cpu_addr),
    .cpu_wdata    (cpu_wdata),
    .cpu_rdata    (cpu_rdata),
    .cpu_rvalid   (cpu_rvalid),
    .stall        (stall),
    .exp_valid    (exp_valid),
    .exp_data     (exp_data),
    .end_run      (end_run),
    .mismatch_cnt (mismatch_cnt),
    .fail_cnt     (fail_cnt),
    .read_cnt     (read_cnt)
  );

  function automatic logic [cache_pkg::data_w-1:0] init_word(
    input logic [cache_pkg::addr_w-1:0] a
  );
    logic [cache_pkg::data_w-1:0] w;
    w = '0;
    w[cache_pkg::addr_w-1:0] = a;
    return cache_pkg::mem_init_base + 32'd3 * w;
  endfunction

  function automatic stim_t rd_row(
    input logic [cache_pkg::tag_w-1:0]    t,
    input logic [cache_pkg::index_w-1:0]  i,
    input logic [cache_pkg::offset_w-1:0] o,
    input logic [cache_pkg::data_w-1:0]   exp
  );
    return '{1'b1, 1'b0, {t, i, o}, exp};
  endfunction

  // read of a word that memory still holds at its start value
  function automatic stim_t rd_init(
    input logic [cache_pkg::tag_w-1:0]    t,
    input logic [cache_pkg::index_w-1:0]  i,
    input logic [cache_pkg::offset_w-1:0] o
  );
    return rd_row(t, i, o, init_word({t, i, o}));
  endfunction

  function automatic stim_t wr_row(
    input logic [cache_pkg::tag_w-1:0]    t,
    input logic [cache_pkg::index_w-1:0]  i,
    input logic [cache_pkg::offset_w-1:0] o,
    input logic [cache_pkg::data_w-1:0]   d
  );
    return '{1'b0, 1'b1, {t, i, o}, d};
  endfunction

  task automatic fill_table();
    stim_table[0]  = rd_init(6'h05, 4'h2, 2'd0);                  // clean miss
    stim_table[1]  = rd_init(6'h05, 4'h2, 2'd3);                  // same line hits
    stim_table[2]  = rd_init(6'h05, 4'h2, 2'd1);
    stim_table[3]  = wr_row(6'h05, 4'h2, 2'd1, 32'ha1a1_0001);    // write hit
    stim_table[4]  = rd_row(6'h05, 4'h2, 2'd1, 32'ha1a1_0001);
    stim_table[5]  = rd_init(6'h05, 4'h2, 2'd2);
    stim_table[6]  = rd_row(6'h05, 4'h2, 2'd1, 32'ha1a1_0001);
    stim_table[7]  = rd_init(6'h09, 4'h2, 2'd1);                  // evicts the dirty line
    stim_table[8]  = rd_row(6'h05, 4'h2, 2'd1, 32'ha1a1_0001);    // back from memory
    stim_table[9]  = rd_init(6'h05, 4'h2, 2'd0);
    stim_table[10] = wr_row(6'h12, 4'h7, 2'd2, 32'hb2b2_0002);    // write allocate
    stim_table[11] = rd_row(6'h12, 4'h7, 2'd2, 32'hb2b2_0002);
    stim_table[12] = rd_init(6'h12, 4'h7, 2'd0);                  // neighbors intact
    stim_table[13] = rd_init(6'h12, 4'h7, 2'd3);
    stim_table[14] = wr_row(6'h12, 4'h7, 2'd0, 32'hc0c0_0000);
    stim_table[15] = wr_row(6'h30, 4'h7, 2'd1, 32'hd1d1_0001);    // write miss, dirty victim
    stim_table[16] = rd_row(6'h30, 4'h7, 2'd1, 32'hd1d1_0001);
    stim_table[17] = rd_row(6'h12, 4'h7, 2'd2, 32'hb2b2_0002);
    stim_table[18] = rd_row(6'h12, 4'h7, 2'd0, 32'hc0c0_0000);
    stim_table[19] = rd_init(6'h30, 4'h7, 2'd0);
    stim_table[20] = rd_row(6'h30, 4'h7, 2'd1, 32'hd1d1_0001);
    stim_table[21] = wr_row(6'h00, 4'h0, 2'd0, 32'he0e0_0000);
    stim_table[22] = rd_init(6'h3f, 4'hf, 2'd3);
    stim_table[23] = rd_row(6'h00, 4'h0, 2'd0, 32'he0e0_0000);
  endtask

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // four tags on four indices, so lines collide often
  function automatic stim_t random_req();
    logic [31:0]                    v;
    logic                           wr;
    logic [1:0]                     t;
    logic [1:0]                     i;
    logic [cache_pkg::offset_w-1:0] o;
    v  = take_bits(1);
    wr = v[0];
    v  = take_bits(2);
    t  = v[1:0];
    v  = take_bits(2);
    i  = v[1:0];
    v  = take_bits(2);
    o  = v[1:0];
    v  = take_bits(32);
    return '{~wr, wr, {rand_tags[t], i, 2'b10, o}, v};
  endfunction

  // hold the request until an edge takes it with stall low
  task automatic send(input stim_t s, input logic use_table);
    @(negedge clk);
    cpu_rden     = s.rden;
    cpu_wren     = s.wren;
    cpu_addr.raw = s.addr;
    cpu_wdata    = s.wren ? s.data : '0;
    exp_valid    = use_table & s.rden;
    exp_data     = s.data;
    do begin
      @(posedge clk);
    end while (stall);
  endtask

  task automatic drain();
    @(negedge clk);
    cpu_rden  = 1'b0;
    cpu_wren  = 1'b0;
    exp_valid = 1'b0;
    do begin
      @(posedge clk);
    end while (stall);   // last miss has finished
  endtask

  initial begin
    clk = 1'b0;
    forever #(cycle_ns / 2) clk = ~clk;
  end

  initial begin
    #(max_cycles * cycle_ns);
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    stim_t s;
    int    reads_sent;
    int    total_errs;
    rst          = 1'b1;
    cpu_rden     = 1'b0;
    cpu_wren     = 1'b0;
    cpu_addr.raw = '0;
    cpu_wdata    = '0;
    exp_valid    = 1'b0;
    exp_data     = '0;
    end_run      = 1'b0;
    lfsr_q       = 32'd71239;
    rand_tags[0] = 6'h03;
    rand_tags[1] = 6'h11;
    rand_tags[2] = 6'h24;
    rand_tags[3] = 6'h3e;
    reads_sent   = 0;
    fill_table();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < table_rows; r++) begin
      s = stim_table[r];
      send(s, 1'b1);
      reads_sent += int'(s.rden);
    end
    for (int n = 0; n < random_reqs; n++) begin
      s = random_req();
      send(s, 1'b0);
      reads_sent += int'(s.rden);
    end
    drain();
    @(negedge clk);
    end_run = 1'b1;
    @(posedge clk);
    @(negedge clk);
    total_errs = mismatch_cnt + fail_cnt;
    if (read_cnt != reads_sent) begin
      $display("only %0d of %0d reads were checked", read_cnt, reads_sent);
      total_errs++;
    end
    $display("errors %0d (mismatches %0d, other %0d), reads checked %0d",
             total_errs, mismatch_cnt, total_errs - mismatch_cnt, read_cnt);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/cache_pkg.sv
hdl/cache_fsm.sv
hdl/cache_store.sv
hdl/main_mem.sv
hdl/cache_top.sv
verification/cache_checker.sv
verification/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FLIST     ?= vlog.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove $(OBJDIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJDIR"

test:
	$(VERILATOR) --binary --timescale 1ns/1ps --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
